//--- verilog/core_shell_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, key state type and the default scrambling
// key and nonce of the core shell
////////////////////////////////////////////////////////////

package core_shell_pkg;

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////

  parameter int unsigned DATA_W     = 32;
  parameter int unsigned REG_ADDR_W = 5;

  ////////////////////////////////////////////////////////////
  // Instruction-cache scrambling
  ////////////////////////////////////////////////////////////

  parameter int unsigned KEY_W   = 128;
  parameter int unsigned NONCE_W = 64;

  // Loaded at reset until a fresh key arrives
  parameter logic [KEY_W-1:0] RND_CNST_KEY_DEFAULT =
    128'h14e8_cecb_a8e6_7a5f_c2d3_b9a1_0e77_4d96;
  parameter logic [NONCE_W-1:0] RND_CNST_NONCE_DEFAULT =
    64'hf79e_a2c4_1d58_b033;

  typedef enum logic {
    KEY_READY,   // key valid, nothing pending
    KEY_REQUEST  // key invalid, request held high
  } key_state_e;

endpackage

//--- verilog/rf_if.sv
////////////////////////////////////////////////////////////
// Register file bus with two read ports and one write port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface rf_if import core_shell_pkg::*; ();

  logic [REG_ADDR_W-1:0] raddr_a;
  logic [REG_ADDR_W-1:0] raddr_b;
  logic [DATA_W-1:0]     rdata_a;
  logic [DATA_W-1:0]     rdata_b;
  logic [REG_ADDR_W-1:0] waddr;
  logic [DATA_W-1:0]     wdata;
  logic                  we;

  // Storage side
  modport regfile (input raddr_a, raddr_b, waddr, wdata, we, output rdata_a, rdata_b);

  // Core side, driven from the shell ports
  modport shell (output raddr_a, raddr_b, waddr, wdata, we, input rdata_a, rdata_b);

endinterface

//--- verilog/register_file_ff.sv
////////////////////////////////////////////////////////////
// Flip-flop register file, two combinational reads, one
// write, register 0 and unused addresses read zero
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module register_file_ff import core_shell_pkg::*; #(
  parameter int unsigned NumRegs = 32
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  rf_if.regfile rf
);

  localparam int unsigned NumAddr = 2 ** REG_ADDR_W;

  // Full address space, so every read index is in range
  logic [DATA_W-1:0] rf_word [NumAddr];

  for (genvar i = 0; i < NumAddr; i++) begin : g_word
    if (i == 0 || i >= NumRegs) begin : g_zero
      assign rf_word[i] = '0;
    end else begin : g_flop
      logic              we_word;
      logic [DATA_W-1:0] word_q;

      assign we_word = rf.we & (rf.waddr == REG_ADDR_W'(i));

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          word_q <= '0;
        end else if (we_word) begin
          word_q <= rf.wdata;
        end
      end

      assign rf_word[i] = word_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////

  assign rf.rdata_a = rf_word[rf.raddr_a];
  assign rf.rdata_b = rf_word[rf.raddr_b];

endmodule

//--- verilog/core_clock_gate.sv
////////////////////////////////////////////////////////////
// Core clock gate: busy register, wake-up OR, latch gate
// and sleep indication
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_clock_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic clk_o,
  output logic core_sleep_o
);

  logic core_busy_q;
  logic clock_en;
  logic en_latch;

  // Busy flag on the free-running clock
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Any wake source keeps the core clocked
  assign clock_en     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  ////////////////////////////////////////////////////////////
  // Glitch-free gate
  ////////////////////////////////////////////////////////////

  // Enable only moves while the clock is low
  always_latch begin
    if (!clk_i) begin
      en_latch <= clock_en;
    end
  end

  assign clk_o = clk_i & en_latch;

endmodule

//--- verilog/scramble_key_ctrl.sv
////////////////////////////////////////////////////////////
// Scrambling key refresh: request/valid state machine and
// key and nonce store
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scramble_key_ctrl import core_shell_pkg::*; #(
  parameter logic [KEY_W-1:0]   RndCnstKey   = RND_CNST_KEY_DEFAULT,
  parameter logic [NONCE_W-1:0] RndCnstNonce = RND_CNST_NONCE_DEFAULT
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               icache_inval_i,
  input  logic               scramble_key_valid_i,
  input  logic [KEY_W-1:0]   scramble_key_i,
  input  logic [NONCE_W-1:0] scramble_nonce_i,
  output logic               scramble_req_o,
  output logic               key_valid_o,
  output logic [KEY_W-1:0]   key_o,
  output logic [NONCE_W-1:0] nonce_o
);

  key_state_e         key_state_q;
  key_state_e         key_state_d;
  logic [KEY_W-1:0]   key_q;
  logic [NONCE_W-1:0] nonce_q;

  ////////////////////////////////////////////////////////////
  // Key state
  ////////////////////////////////////////////////////////////

  // Invalidates are ignored while a request is open
  always_comb begin
    key_state_d = key_state_q;
    case (key_state_q)
      KEY_READY: begin
        if (icache_inval_i) begin
          key_state_d = KEY_REQUEST;
        end
      end
      KEY_REQUEST: begin
        if (scramble_key_valid_i) begin
          key_state_d = KEY_READY;
        end
      end
      default: key_state_d = KEY_READY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_state_q <= KEY_READY;
    end else begin
      key_state_q <= key_state_d;
    end
  end

  assign scramble_req_o = (key_state_q == KEY_REQUEST);
  assign key_valid_o    = (key_state_q == KEY_READY);

  ////////////////////////////////////////////////////////////
  // Key and nonce store
  ////////////////////////////////////////////////////////////

  // Any offered key is taken, requested or not
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= RndCnstKey;
      nonce_q <= RndCnstNonce;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  assign key_o   = key_q;
  assign nonce_o = nonce_q;

endmodule

//--- verilog/core_shell_top.sv
////////////////////////////////////////////////////////////
// Core shell top level: clock gate, flip-flop register file
// and scrambling key refresh behind plain ports
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_shell_top import core_shell_pkg::*; #(
  parameter int unsigned        NumRegs      = 32,
  parameter logic [KEY_W-1:0]   RndCnstKey   = RND_CNST_KEY_DEFAULT,
  parameter logic [NONCE_W-1:0] RndCnstNonce = RND_CNST_NONCE_DEFAULT
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Wake sources
  input  logic                  core_busy_i,
  input  logic                  debug_req_i,
  input  logic                  irq_pending_i,
  input  logic                  irq_nm_i,

  // Register file
  input  logic [REG_ADDR_W-1:0] rf_raddr_a_i,
  input  logic [REG_ADDR_W-1:0] rf_raddr_b_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  logic [DATA_W-1:0]     rf_wdata_i,
  input  logic                  rf_we_i,
  output logic [DATA_W-1:0]     rf_rdata_a_o,
  output logic [DATA_W-1:0]     rf_rdata_b_o,

  // Scrambling key
  input  logic                  icache_inval_i,
  input  logic                  scramble_key_valid_i,
  input  logic [KEY_W-1:0]      scramble_key_i,
  input  logic [NONCE_W-1:0]    scramble_nonce_i,

  output logic                  core_sleep_o,
  output logic                  scramble_req_o,
  output logic                  key_valid_o,
  output logic [KEY_W-1:0]      key_o,
  output logic [NONCE_W-1:0]    nonce_o
);

  logic clk_core;

  rf_if rf_bus ();

  ////////////////////////////////////////////////////////////
  // Clock gate
  ////////////////////////////////////////////////////////////

  core_clock_gate u_core_clock_gate (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .clk_o        (clk_core),
    .core_sleep_o (core_sleep_o)
  );

  ////////////////////////////////////////////////////////////
  // Register file on the gated clock
  ////////////////////////////////////////////////////////////

  assign rf_bus.raddr_a = rf_raddr_a_i;
  assign rf_bus.raddr_b = rf_raddr_b_i;
  assign rf_bus.waddr   = rf_waddr_i;
  assign rf_bus.wdata   = rf_wdata_i;
  assign rf_bus.we      = rf_we_i;
  assign rf_rdata_a_o   = rf_bus.rdata_a;
  assign rf_rdata_b_o   = rf_bus.rdata_b;

  register_file_ff #(
    .NumRegs(NumRegs)
  ) u_register_file_ff (
    .clk_i (clk_core),
    .rst_ni(rst_ni),
    .rf    (rf_bus)
  );

  ////////////////////////////////////////////////////////////
  // Scrambling key refresh
  ////////////////////////////////////////////////////////////

  scramble_key_ctrl #(
    .RndCnstKey  (RndCnstKey),
    .RndCnstNonce(RndCnstNonce)
  ) u_scramble_key_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .icache_inval_i      (icache_inval_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .key_valid_o         (key_valid_o),
    .key_o               (key_o),
    .nonce_o             (nonce_o)
  );

endmodule

//--- dv/core_shell_tb.sv
////////////////////////////////////////////////////////////
// Core shell testbench: clock, reset, LCG stimulus, model of
// register file, clock gate and key refresh, checks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_shell_tb import core_shell_pkg::*; ();

  localparam int unsigned NUM_REGS   = 32;
  localparam int          WAIT_LIMIT = 8;

  logic                  clk;
  logic                  rst_n;
  logic                  core_busy;
  logic                  debug_req;
  logic                  irq_pending;
  logic                  irq_nm;
  logic [REG_ADDR_W-1:0] raddr_a;
  logic [REG_ADDR_W-1:0] raddr_b;
  logic [REG_ADDR_W-1:0] waddr;
  logic [DATA_W-1:0]     wdata;
  logic                  we;
  logic [DATA_W-1:0]     rdata_a;
  logic [DATA_W-1:0]     rdata_b;
  logic                  icache_inval;
  logic                  key_valid_in;
  logic [KEY_W-1:0]      key_in;
  logic [NONCE_W-1:0]    nonce_in;
  logic                  core_sleep;
  logic                  scramble_req;
  logic                  key_valid;
  logic [KEY_W-1:0]      key_out;
  logic [NONCE_W-1:0]    nonce_out;

  // Reference model
  logic [DATA_W-1:0]     shadow [NUM_REGS];
  logic                  busy_m;
  key_state_e            key_state_m;
  logic [KEY_W-1:0]      key_m;
  logic [NONCE_W-1:0]    nonce_m;

  logic [31:0] rand_state;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;

  core_shell_top #(
    .NumRegs(NUM_REGS)
  ) i_core_shell_top (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .core_busy_i         (core_busy),
    .debug_req_i         (debug_req),
    .irq_pending_i       (irq_pending),
    .irq_nm_i            (irq_nm),
    .rf_raddr_a_i        (raddr_a),
    .rf_raddr_b_i        (raddr_b),
    .rf_waddr_i          (waddr),
    .rf_wdata_i          (wdata),
    .rf_we_i             (we),
    .rf_rdata_a_o        (rdata_a),
    .rf_rdata_b_o        (rdata_b),
    .icache_inval_i      (icache_inval),
    .scramble_key_valid_i(key_valid_in),
    .scramble_key_i      (key_in),
    .scramble_nonce_i    (nonce_in),
    .core_sleep_o        (core_sleep),
    .scramble_req_o      (scramble_req),
    .key_valid_o         (key_valid),
    .key_o               (key_out),
    .nonce_o             (nonce_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic [KEY_W-1:0] rand_key();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  function automatic logic [NONCE_W-1:0] rand_nonce();
    return {next_rand(), next_rand()};
  endfunction

  task automatic report_mismatch(input string name, input logic [KEY_W-1:0] got,
                                 input logic [KEY_W-1:0] exp);
    $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    errors++;
  endtask

  // Model the rising edge, then move to the next falling edge
  task automatic tick();
    logic gate_open;
    gate_open = busy_m | debug_req | irq_pending | irq_nm;
    if (gate_open && we && waddr != 0 && waddr < NUM_REGS) begin
      shadow[waddr] = wdata;
    end
    if (key_state_m == KEY_READY) begin
      if (icache_inval) begin
        key_state_m = KEY_REQUEST;
      end
    end else if (key_valid_in) begin
      key_state_m = KEY_READY;
    end
    if (key_valid_in) begin
      key_m   = key_in;
      nonce_m = nonce_in;
    end
    busy_m = core_busy;
    @(negedge clk);
  endtask

  task automatic check_outputs();
    logic exp_sleep;
    exp_sleep = ~(busy_m | debug_req | irq_pending | irq_nm);
    if (core_sleep !== exp_sleep) report_mismatch("core_sleep_o", core_sleep, exp_sleep);
    if (scramble_req !== (key_state_m == KEY_REQUEST))
      report_mismatch("scramble_req_o", scramble_req, key_state_m == KEY_REQUEST);
    if (key_valid !== (key_state_m == KEY_READY))
      report_mismatch("key_valid_o", key_valid, key_state_m == KEY_READY);
    if (key_out !== key_m) report_mismatch("key_o", key_out, key_m);
    if (nonce_out !== nonce_m) report_mismatch("nonce_o", nonce_out, nonce_m);
    if (rdata_a !== shadow[raddr_a]) report_mismatch("rf_rdata_a_o", rdata_a, shadow[raddr_a]);
    if (rdata_b !== shadow[raddr_b]) report_mismatch("rf_rdata_b_o", rdata_b, shadow[raddr_b]);
  endtask

  task automatic end_run();
    $display("Tests run: %0d, failed: %0d, check errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // Single-cycle pulses drop after the first edge
  task automatic wait_req(input logic level, output int cycles);
    cycles = 0;
    do begin
      tick();
      check_outputs();
      icache_inval = 1'b0;
      key_valid_in = 1'b0;
      cycles++;
    end while (scramble_req !== level && cycles < WAIT_LIMIT);
    if (scramble_req !== level) begin
      $display("Timeout: scramble request never went to %0b", level);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s with %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin
    int                 n;
    int                 cycles;
    int                 delay;
    logic [KEY_W-1:0]   offered_key;
    logic [NONCE_W-1:0] offered_nonce;
    rand_state   = 32'hd5e911ef;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    core_busy    = 1'b0;
    debug_req    = 1'b0;
    irq_pending  = 1'b0;
    irq_nm       = 1'b0;
    raddr_a      = '0;
    raddr_b      = '0;
    waddr        = '0;
    wdata        = '0;
    we           = 1'b0;
    icache_inval = 1'b0;
    key_valid_in = 1'b0;
    key_in       = '0;
    nonce_in     = '0;
    for (n = 0; n < NUM_REGS; n++) begin
      shadow[n] = '0;
    end
    busy_m      = 1'b0;
    key_state_m = KEY_READY;
    key_m       = RND_CNST_KEY_DEFAULT;
    nonce_m     = RND_CNST_NONCE_DEFAULT;

    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    check_outputs();
    tick();
    check_outputs();
    finish_test("reset values");

    core_busy = 1'b1;
    tick();
    check_outputs();
    for (n = 0; n < 200; n++) begin
      we      = (n % 16 == 0) ? 1'b1 : 1'(next_rand() >> 31);
      waddr   = (n % 16 == 0) ? '0 : REG_ADDR_W'(next_rand() >> 27);
      wdata   = next_rand();
      raddr_a = (n % 16 == 8) ? '0 : REG_ADDR_W'(next_rand() >> 27);
      raddr_b = (n % 2 == 0) ? waddr : REG_ADDR_W'(next_rand() >> 27);
      tick();
      check_outputs();
    end
    we = 1'b0;
    finish_test("random register writes and reads");

    // Idle writes before and after the three wake sources in turn
    core_busy = 1'b0;
    tick();
    check_outputs();
    for (n = 0; n < 30; n++) begin
      debug_req   = (n / 5 == 2);
      irq_pending = (n / 5 == 3);
      irq_nm      = (n / 5 == 4);
      we          = 1'b1;
      waddr       = REG_ADDR_W'(next_rand() >> 27);
      wdata       = next_rand();
      raddr_a     = waddr;
      raddr_b     = REG_ADDR_W'(next_rand() >> 27);
      tick();
      check_outputs();
    end
    we = 1'b0;
    finish_test("gated writes are lost");

    for (n = 0; n < 3; n++) begin
      icache_inval = 1'b1;
      wait_req(1'b1, cycles);
      if (cycles != 1) begin
        $display("Request rose %0d cycles after the invalidate instead of one", cycles);
        errors++;
      end
      delay = 2 + int'(next_rand() >> 29);
      repeat (delay) begin
        icache_inval = 1'(next_rand() >> 31);
        key_in       = rand_key();
        tick();
        check_outputs();
      end
      icache_inval  = 1'b0;
      offered_key   = rand_key();
      offered_nonce = rand_nonce();
      key_in        = offered_key;
      nonce_in      = offered_nonce;
      key_valid_in  = 1'b1;
      wait_req(1'b0, cycles);
      if (cycles != 1) begin
        $display("Request dropped %0d cycles after the valid key instead of one", cycles);
        errors++;
      end
      if (key_out !== offered_key) report_mismatch("key_o", key_out, offered_key);
      if (nonce_out !== offered_nonce) report_mismatch("nonce_o", nonce_out, offered_nonce);
    end
    finish_test("key refresh sequence");

    for (n = 0; n < 10; n++) begin
      key_in       = rand_key();
      nonce_in     = rand_nonce();
      key_valid_in = 1'b1;
      tick();
      check_outputs();
      key_valid_in = 1'b0;
      if (key_out !== key_in) report_mismatch("key_o", key_out, key_in);
      if (key_valid !== 1'b1) report_mismatch("key_valid_o", key_valid, 1'b1);
      tick();
      check_outputs();
    end
    finish_test("unrequested key capture");

    end_run();
  end

endmodule

//--- core_shell_top.f
verilog/core_shell_pkg.sv
verilog/rf_if.sv
verilog/register_file_ff.sv
verilog/core_clock_gate.sv
verilog/scramble_key_ctrl.sv
verilog/core_shell_top.sv
dv/core_shell_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = core_shell_tb
FILELIST = core_shell_top.f

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
